// ==== source/gus16_pkg.sv ====
/* GUS16 shared definitions */
package gus16_pkg;

	// ------------------------------------------------------------------------
	// Basic types
	// ------------------------------------------------------------------------
	localparam int WORD_BITS = 16;	// Data and address width

	typedef logic [WORD_BITS-1:0] word_t;	// One data or address word
	typedef logic [2:0] reg_idx_t;	// R0 to R7

	// ------------------------------------------------------------------------
	// Major opcode, IR[15:11]
	// Any word with IR[15] set is a conditional relative jump (JRx)
	// ------------------------------------------------------------------------
	typedef enum logic [4:0] {
		OP_ALU   = 5'b00000,	// ADD SUB ADC SBC by IR[1:0]
		OP_LOGIC = 5'b00001,	// AND OR XOR BIC by IR[1:0]
		OP_ADDI  = 5'b00010,
		OP_SUBI  = 5'b00011,
		OP_ADCI  = 5'b00100,
		OP_SBCI  = 5'b00101,
		OP_ANDI  = 5'b00110,
		OP_ORI   = 5'b00111,
		OP_XORI  = 5'b01000,
		OP_CMPI  = 5'b01001,	// SUBI without register write
		OP_LDI   = 5'b01010,	// 8-bit unsigned load
		OP_MISC  = 5'b01011,	// Shifts, NOT, NEG, LDPC, JIND
		OP_LD    = 5'b01100,
		OP_ST    = 5'b01101,
		OP_JAL   = 5'b01110	// 0111x, IR[11] is the offset sign
	} opcode_e;

	// ALU function code
	typedef enum logic [1:0] {
		FN_ADD = 2'b00,
		FN_XOR = 2'b01,
		FN_OR  = 2'b10,
		FN_AND = 2'b11
	} alu_fn_e;

	// Shift kind, selects the bit filled into the MSB
	typedef enum logic [1:0] {
		SH_NONE = 2'b00,	// Plain rotate (RORI) or no shift
		SH_SHR  = 2'b01,	// Logical, zero fill
		SH_SHRA = 2'b10,	// Arithmetic, sign fill
		SH_RORC = 2'b11	// Through carry
	} shift_e;

endpackage

// ==== source/gus16_fetch.sv ====
/* GUS16 fetch stage */
`timescale 1ns/100ps

module gus16_fetch import gus16_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  word_t cdi,	// Word on the memory bus
	input  logic  jmp,	// Load PC from busd
	input  logic  hold,	// LD or ST owns the bus this cycle
	input  word_t busd,	// Jump target
	output word_t pc,
	output word_t ir,
	output logic  opval	// IR holds an instruction to execute
);

	logic  ldpc_now;
	logic  opval_next;
	word_t pc_next;

	// LDPC reads the word after it as data, so that word is not executed
	assign ldpc_now = opval && (ir[15:11] == OP_MISC) &&
		(ir[7:5] == 3'b111) && (ir[1:0] == 2'b00);

	assign pc_next = jmp ? busd : pc + word_t'(!hold);	// Stays put during LD/ST
	assign opval_next = !(hold || ldpc_now || jmp);	// Bubble after bus use or jump

	// ------------------------------------------------------------------------
	// PC and valid flag
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
			opval <= 1'b0;
		end else begin
			pc <= pc_next;
			opval <= opval_next;
		end
	end

	always_ff @(posedge clk) begin
		ir <= cdi;	// Every bus word is captured
	end

	// First cycle out of reset never executes stale IR contents
	assert property (@(posedge clk) $fell(reset) |-> !opval)
		else $error("fetch: opval set in first cycle after reset");

endmodule

// ==== source/gus16_decode.sv ====
/* GUS16 instruction decode */
`timescale 1ns/100ps

module gus16_decode import gus16_pkg::*; #(
	parameter reg_idx_t LINK_REG = 3'd6	// JAL return register
) (
	input  word_t      ir,
	input  logic       opval,
	input  logic       cond_true,	// Flag test for IR[14:12]
	output reg_idx_t   aa,
	output reg_idx_t   ba,
	output reg_idx_t   da,
	output word_t      busimm,
	output alu_fn_e    fn,
	output shift_e     shift,
	output logic [3:0] rot_amount,
	output logic       zab,	// Pass operand A, else zero
	output logic       ib,	// Invert operand B
	output logic       xa,	// Carry in from C flag
	output logic       imm,	// Operand B from immediate
	output logic       pca,	// Operand A from PC
	output logic       dwr,
	output logic       wrcv,
	output logic       wrzn,
	output logic       is_ld,
	output logic       is_st,
	output logic       is_ldpc,
	output logic       is_jal,
	output logic       jmp
);

	opcode_e op;
	logic    wd;
	logic    wc;
	logic    wz;
	logic    is_misc;
	logic    rori;
	logic    jind;
	logic    opimm;

	assign op = opcode_e'(ir[15:11]);

	// ------------------------------------------------------------------------
	// Control truth table
	// ------------------------------------------------------------------------
	always_comb begin
		fn = FN_OR;	// Idle passes B and writes nothing
		zab = 1'b0;
		ib = 1'b0;
		xa = 1'b0;
		shift = SH_NONE;
		imm = 1'b0;
		wd = 1'b0;
		wc = 1'b0;
		wz = 1'b0;
		pca = 1'b0;
		is_ld = opval && (op == OP_LD);
		is_st = opval && (op == OP_ST);
		if (ir[15]) begin	// JRx, PC + offset
			fn = FN_ADD; zab = 1'b1; imm = 1'b1; pca = 1'b1;
		end else if ({ir[15:12], 1'b0} == OP_JAL) begin
			fn = FN_ADD; zab = 1'b1; imm = 1'b1; pca = 1'b1; wd = 1'b1;
		end else begin
			case (op)
				OP_ALU: begin	// IR[0] subtracts, IR[1] uses carry
					fn = FN_ADD; zab = 1'b1; ib = ir[0]; xa = ir[1];
					wd = 1'b1; wc = 1'b1; wz = 1'b1;
				end
				OP_LOGIC: begin
					fn = (ir[1:0] == 2'b01) ? FN_OR : ((ir[1:0] == 2'b10) ? FN_XOR : FN_AND);
					zab = 1'b1; ib = (ir[1:0] == 2'b11); wd = 1'b1; wz = 1'b1;	// BIC
				end
				OP_ADDI, OP_SUBI, OP_ADCI, OP_SBCI: begin	// Opcode bits map like OP_ALU
					fn = FN_ADD; zab = 1'b1; ib = ir[11]; xa = ir[13]; imm = 1'b1;
					wd = 1'b1; wc = 1'b1; wz = 1'b1;
				end
				OP_ANDI: begin fn = FN_AND; zab = 1'b1; imm = 1'b1; wd = 1'b1; wz = 1'b1; end
				OP_ORI:  begin fn = FN_OR;  zab = 1'b1; imm = 1'b1; wd = 1'b1; wz = 1'b1; end
				OP_XORI: begin fn = FN_XOR; zab = 1'b1; imm = 1'b1; wd = 1'b1; wz = 1'b1; end
				OP_CMPI: begin fn = FN_ADD; zab = 1'b1; ib = 1'b1; imm = 1'b1; wc = 1'b1; wz = 1'b1; end
				OP_LDI:  begin imm = 1'b1; wd = 1'b1; end
				OP_MISC: begin
					if (!ir[7]) begin	// RORI
						wd = 1'b1; wz = 1'b1;
					end else if (ir[6:5] == 2'b00 && ir[1:0] != 2'b11) begin
						shift = (ir[1:0] == 2'b00) ? SH_RORC : shift_e'(ir[1:0]);
						wd = 1'b1; wc = 1'b1; wz = 1'b1;
					end else if (ir[6:5] == 2'b01 && !ir[1]) begin	// NOT, NEG
						fn = ir[0] ? FN_ADD : FN_OR; ib = 1'b1; wd = 1'b1; wz = 1'b1;
					end else if (ir[6:5] == 2'b11 && ir[1:0] == 2'b00) begin
						wd = 1'b1;	// LDPC
					end
				end
				OP_LD: begin fn = FN_ADD; zab = 1'b1; imm = 1'b1; wd = 1'b1; wz = 1'b1; end
				OP_ST: begin fn = FN_ADD; zab = 1'b1; imm = 1'b1; end
				default: ;
			endcase
		end
		// Both come from one opcode compare each
		assert (!(is_ld && is_st)) else $error("decode: LD and ST both active");
	end

	// ------------------------------------------------------------------------
	// Directly decoded lines
	// ------------------------------------------------------------------------
	assign is_jal = opval && ({ir[15:12], 1'b0} == OP_JAL);
	assign is_misc = opval && (op == OP_MISC);
	assign rori = is_misc && !ir[7];
	assign is_ldpc = is_misc && (ir[7:5] == 3'b111) && (ir[1:0] == 2'b00);
	assign jind = is_misc && (ir[7:5] == 3'b111) && ir[1];
	assign opimm = opval && imm && !(is_ld || is_st || is_jal || ir[15]);

	assign jmp = (opval && ir[15] && cond_true) || is_jal || jind;
	assign rot_amount = rori ? {ir[6:5], ir[1:0]} : {3'b000, shift != SH_NONE};

	assign aa = opimm ? ir[10:8] : ir[7:5];	// Immediate ops work in place
	assign ba = is_st ? ir[10:8] : ir[4:2];	// Store data register
	assign da = is_jal ? LINK_REG : ir[10:8];

	assign busimm[4:0] = ir[4:0];
	assign busimm[7:5] = (ir[15] || is_jal || opimm) ? ir[7:5] : 3'b000;
	assign busimm[15:8] = (ir[15] || is_jal) ? {{4{ir[11]}}, ir[11:8]} : 8'h00;

	assign dwr = opval && wd;
	assign wrcv = opval && wc;
	assign wrzn = opval && wz;

endmodule

// ==== source/gus16_execute.sv ====
/* GUS16 ALU and shifter */
`timescale 1ns/100ps

module gus16_execute import gus16_pkg::*; (
	input  word_t      rega,
	input  word_t      regb,
	input  word_t      pc,
	input  word_t      busimm,
	input  alu_fn_e    fn,
	input  shift_e     shift,
	input  logic [3:0] rot_amount,	// Right rotate 0 to 15
	input  logic       zab,
	input  logic       ib,
	input  logic       xa,
	input  logic       imm,
	input  logic       pca,
	input  logic       cf,
	output word_t      aluf,	// Also the LD/ST address
	output word_t      y,
	output logic       cd,
	output logic       vd
);

	localparam int MSB = WORD_BITS - 1;

	word_t              alua;
	word_t              alub;
	word_t              sa;
	word_t              sb;
	logic               c0;
	logic               c15;
	logic [WORD_BITS:0] sum;
	logic               bsi0;
	word_t              bsi;
	word_t              bsl1;
	word_t              bsl2;
	word_t              bsl3;

	// ------------------------------------------------------------------------
	// Operands and ALU
	// ------------------------------------------------------------------------
	assign alua = pca ? pc : rega;
	assign alub = imm ? busimm : regb;
	assign c0 = xa ? cf : ib;	// SUB gets +1 from ib
	assign sa = zab ? alua : '0;
	assign sb = ib ? ~alub : alub;
	assign sum = {1'b0, sa} + {1'b0, sb} + {{WORD_BITS{1'b0}}, c0};

	always_comb begin
		c15 = 1'b0;
		case (fn)
			FN_ADD: begin
				aluf = sum[MSB:0];
				c15 = sum[WORD_BITS];
			end
			FN_XOR: aluf = sa ^ sb;
			FN_OR:  aluf = sa | sb;	// Also the pass-through for B
			default: aluf = sa & sb;
		endcase
	end

	// Signed overflow of the adder
	assign vd = (!sb[MSB] && !sa[MSB] && aluf[MSB]) || (sb[MSB] && sa[MSB] && !aluf[MSB]);

	// ------------------------------------------------------------------------
	// Barrel rotator, LSB replaced before rotating into the MSB
	// ------------------------------------------------------------------------
	always_comb begin
		case (shift)
			SH_SHR:  bsi0 = 1'b0;
			SH_SHRA: bsi0 = aluf[MSB];	// Sign copy
			SH_RORC: bsi0 = cf;
			default: bsi0 = aluf[0];	// Plain rotate
		endcase
	end

	assign bsi = {aluf[MSB:1], bsi0};
	assign bsl1 = rot_amount[3] ? {bsi[7:0], bsi[15:8]} : bsi;
	assign bsl2 = rot_amount[2] ? {bsl1[3:0], bsl1[15:4]} : bsl1;
	assign bsl3 = rot_amount[1] ? {bsl2[1:0], bsl2[15:2]} : bsl2;
	assign y = rot_amount[0] ? {bsl3[0], bsl3[15:1]} : bsl3;

	assign cd = (shift != SH_NONE) ? alub[0] : c15;	// Shifted-out bit or adder carry

endmodule

// ==== source/gus16_result.sv ====
/* GUS16 register bank and flags */
`timescale 1ns/100ps

module gus16_result import gus16_pkg::*; (
	input  logic       clk,
	input  reg_idx_t   aa,
	input  reg_idx_t   ba,
	input  reg_idx_t   da,
	input  logic       dwr,
	input  logic       wrcv,
	input  logic       wrzn,
	input  logic       is_ld,
	input  logic       is_ldpc,
	input  logic       is_jal,
	input  word_t      y,
	input  word_t      pc,
	input  word_t      cdi,
	input  logic       cd,
	input  logic       vd,
	input  logic [2:0] cond_sel,	// IR[14:12]
	output word_t      rega,
	output word_t      regb,
	output word_t      busd,
	output logic       cf,
	output logic       cond_true
);

	word_t      regs [8];
	logic       vf;
	logic       zf;
	logic       nf;
	logic [7:0] ccond;

	assign busd = (is_ld || is_ldpc) ? cdi : y;	// Memory data or shifter

	always_ff @(posedge clk) begin
		if (dwr) regs[da] <= is_jal ? pc : busd;	// JAL links the return address
	end

	assign rega = regs[aa];
	assign regb = regs[ba];

	// ------------------------------------------------------------------------
	// Flags and jump condition
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wrcv) begin
			cf <= cd;
			vf <= vd;
		end
		if (wrzn) begin
			zf <= (busd == '0);
			nf <= busd[WORD_BITS-1];
		end
	end

	assign ccond = {1'b1, vf, !nf, nf, !cf, cf, !zf, zf};	// 7 is always
	assign cond_true = ccond[cond_sel];

endmodule

// ==== source/gus16_core.sv ====
/* GUS16 processor core */
`timescale 1ns/100ps

module gus16_core import gus16_pkg::*; #(
	parameter reg_idx_t LINK_REG = 3'd6	// JAL return register
) (
	input  logic  clk,
	input  logic  reset,
	input  word_t cdi,	// Read data, same cycle as ca
	output word_t ca,
	output word_t cdo,
	output logic  we	// One cycle per store
);

	word_t      pc;
	word_t      ir;
	logic       opval;
	reg_idx_t   aa;
	reg_idx_t   ba;
	reg_idx_t   da;
	word_t      busimm;
	alu_fn_e    fn;
	shift_e     shift;
	logic [3:0] rot_amount;
	logic       zab;
	logic       ib;
	logic       xa;
	logic       imm;
	logic       pca;
	logic       dwr;
	logic       wrcv;
	logic       wrzn;
	logic       is_ld;
	logic       is_st;
	logic       is_ldpc;
	logic       is_jal;
	logic       jmp;
	logic       cond_true;
	word_t      rega;
	word_t      regb;
	word_t      busd;
	logic       cf;
	word_t      aluf;
	word_t      y;
	logic       cd;
	logic       vd;

	// ------------------------------------------------------------------------
	// Stages
	// ------------------------------------------------------------------------
	gus16_fetch gus16_fetch_inst (
		.clk(clk), .reset(reset), .cdi(cdi), .jmp(jmp),
		.hold(is_ld || is_st), .busd(busd),
		.pc(pc), .ir(ir), .opval(opval)
	);

	gus16_decode #(.LINK_REG(LINK_REG)) gus16_decode_inst (
		.ir(ir), .opval(opval), .cond_true(cond_true),
		.aa(aa), .ba(ba), .da(da), .busimm(busimm), .fn(fn), .shift(shift),
		.rot_amount(rot_amount), .zab(zab), .ib(ib), .xa(xa), .imm(imm), .pca(pca),
		.dwr(dwr), .wrcv(wrcv), .wrzn(wrzn), .is_ld(is_ld), .is_st(is_st),
		.is_ldpc(is_ldpc), .is_jal(is_jal), .jmp(jmp)
	);

	gus16_execute gus16_execute_inst (
		.rega(rega), .regb(regb), .pc(pc), .busimm(busimm), .fn(fn), .shift(shift),
		.rot_amount(rot_amount), .zab(zab), .ib(ib), .xa(xa), .imm(imm), .pca(pca),
		.cf(cf), .aluf(aluf), .y(y), .cd(cd), .vd(vd)
	);

	gus16_result gus16_result_inst (
		.clk(clk), .aa(aa), .ba(ba), .da(da), .dwr(dwr), .wrcv(wrcv), .wrzn(wrzn),
		.is_ld(is_ld), .is_ldpc(is_ldpc), .is_jal(is_jal), .y(y), .pc(pc), .cdi(cdi),
		.cd(cd), .vd(vd), .cond_sel(ir[14:12]),
		.rega(rega), .regb(regb), .busd(busd), .cf(cf), .cond_true(cond_true)
	);

	// ------------------------------------------------------------------------
	// Memory bus
	// ------------------------------------------------------------------------
	assign ca = (is_ld || is_st) ? aluf : pc;	// Effective address or fetch
	assign cdo = regb;
	assign we = is_st;

	// Fetch bubble after ST keeps the strobe to a single cycle
	assert property (@(posedge clk) disable iff (reset) we |=> !we)
		else $error("core: we high for two cycles");

endmodule

// ==== dv/tb_gus16.sv ====
/* GUS16 core testbench */
`timescale 1ns/100ps

module tb_gus16 import gus16_pkg::*; ();

	localparam int CLK_NS = 10;
	localparam int NUM_RUNS = 8;	// Programs loaded over the whole run
	localparam int TIMEOUT_NS = 200 * NUM_RUNS * CLK_NS;
	localparam int SUB_ADDR = 64;	// Subroutine for the JAL program
	localparam reg_idx_t LINK = 3'd6;

	logic  clk = 1'b0;
	logic  reset;
	word_t cdi;
	word_t ca;
	word_t cdo;
	logic  we;

	word_t      mem [256] = '{default: '0};
	word_t      image [256];	// Copied into mem while reset is high
	word_t      prog [$];
	logic [7:0] log_addr [$];	// Every store since the last reset
	word_t      log_data [$];
	int         end_count = 0;	// Stores to 0xFF seen
	int         fail_count = 0;
	int         seed;

	gus16_core #(.LINK_REG(LINK)) gus16_core_inst (
		.clk(clk), .reset(reset), .cdi(cdi), .ca(ca), .cdo(cdo), .we(we)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// ------------------------------------------------------------------------
	// Memory model
	// ------------------------------------------------------------------------
	assign cdi = mem[ca[7:0]];	// Same-cycle read

	always @(posedge clk) begin
		if (reset) begin
			mem <= image;
			log_addr.delete();
			log_data.delete();
		end else if (we) begin
			mem[ca[7:0]] <= cdo;
			log_addr.push_back(ca[7:0]);
			log_data.push_back(cdo);
			if (ca[7:0] == 8'hFF) end_count = end_count + 1;	// End marker
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: a program did not reach its end store within %0d ns", TIMEOUT_NS);
		$display("TB FAILED");
		$fatal(1, "Watchdog expired");
	end

	// ------------------------------------------------------------------------
	// Error reporting and instruction words
	// ------------------------------------------------------------------------
	task automatic fail_now(string why);
		$display("%s", why);
		fail_count++;
		$display("TB FAILED");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic report_mismatch(string name, word_t expected, word_t got);
		fail_now($sformatf("MISMATCH at %0t: %s expected 0x%04h got 0x%04h",
			$time, name, expected, got));
	endtask

	function automatic word_t ri_word(opcode_e op, reg_idx_t rd, logic [7:0] k);
		return {op, rd, k};	// Immediate ops, CMPI, LDI
	endfunction

	function automatic word_t rrr_word(opcode_e op, reg_idx_t rd, reg_idx_t ra,
		reg_idx_t rb, logic [1:0] f);
		return {op, rd, ra, rb, f};
	endfunction

	function automatic word_t misc_word(reg_idx_t rd, logic [2:0] sel, reg_idx_t rs,
		logic [1:0] f);
		return {OP_MISC, rd, sel, rs, f};
	endfunction

	function automatic word_t mem_word(opcode_e op, reg_idx_t r, reg_idx_t base,
		logic [4:0] off);
		return {op, r, base, off};	// ST data or LD destination in r
	endfunction

	function automatic word_t branch_word(logic [2:0] cond, logic [11:0] off);
		return {1'b1, cond, off};	// Target is next address plus off
	endfunction

	function automatic word_t jal_word(logic [11:0] off);
		return {4'b0111, off};
	endfunction

	// ------------------------------------------------------------------------
	// Program building and running
	// ------------------------------------------------------------------------
	task automatic emit(word_t w);
		prog.push_back(w);
	endtask

	task automatic open_program();
		prog.delete();
		emit(ri_word(OP_LDI, 3'd0, 8'h80));	// R0 is the result base
		emit(ri_word(OP_LDI, 3'd7, 8'hFF));
	endtask

	task automatic close_program();
		emit(mem_word(OP_ST, 3'd7, 3'd7, 5'd0));	// Store to 0xFF ends the program
		emit(branch_word(3'd7, 12'hFFF));	// Jump to self
	endtask

	task automatic load_word(reg_idx_t rd, word_t v);
		emit(ri_word(OP_LDI, rd, v[15:8]));
		emit(misc_word(rd, 3'b010, rd, 2'b00));	// RORI by 8
		emit(ri_word(OP_ADDI, rd, v[7:0]));
	endtask

	task automatic store_result(reg_idx_t r, logic [4:0] off);
		emit(mem_word(OP_ST, r, 3'd0, off));	// To 0x80 + off
	endtask

	task automatic run_program(string label);
		int start;
		foreach (image[i]) image[i] = {8'(i), ~8'(i)};
		foreach (prog[i]) image[i] = prog[i];
		start = end_count;
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (10) begin
			@(posedge clk);
			#1;
			assert (we == 1'b0) else report_mismatch({label, ": we in reset"}, '0, word_t'(we));
			assert (ca == '0) else report_mismatch({label, ": ca in reset"}, '0, ca);
		end
		reset = 1'b0;
		#1;
		assert (ca == '0) else report_mismatch({label, ": first fetch ca"}, '0, ca);
		wait (end_count != start);
	endtask

	task automatic check_store(logic [7:0] addr, word_t expected, string name);
		bit    found;
		word_t got;
		found = 1'b0;
		got = '0;
		for (int i = 0; i < log_addr.size(); i++) begin
			if (log_addr[i] == addr) begin
				found = 1'b1;
				got = log_data[i];	// Last store wins
			end
		end
		assert (found) else fail_now($sformatf("No store to address 0x%02h for %s", addr, name));
		assert (got == expected) else report_mismatch(name, expected, got);
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic alu_register_test();
		word_t      a;
		word_t      b;
		logic [16:0] s;
		a = word_t'($random(seed));
		b = word_t'($random(seed));
		open_program();
		load_word(3'd1, a);
		load_word(3'd2, b);
		for (int f = 0; f < 4; f++) begin	// ADD SUB ADC SBC, AND OR XOR BIC
			emit(rrr_word(OP_ALU, 3'd3, 3'd1, 3'd2, 2'(f)));
			store_result(3'd3, 5'(f));
			emit(rrr_word(OP_LOGIC, 3'd4, 3'd1, 3'd2, 2'(f)));	// Leaves C alone
			store_result(3'd4, 5'(f + 4));
		end
		close_program();
		run_program("register ALU");
		s = 17'(a) + 17'(b) + 17'(a >= b);	// C after SUB means no borrow
		check_store(8'h80, a + b, "ADD");
		check_store(8'h81, a - b, "SUB");
		check_store(8'h82, s[15:0], "ADC");
		check_store(8'h83, a - b - word_t'(!s[16]), "SBC");
		check_store(8'h84, a & b, "AND");
		check_store(8'h85, a | b, "OR");
		check_store(8'h86, a ^ b, "XOR");
		check_store(8'h87, a & ~b, "BIC");
	endtask

	task automatic alu_immediate_test();
		opcode_e     ops [8];
		logic [7:0]  k [8];
		word_t       v;
		logic        c;
		logic [16:0] s;
		ops = '{OP_ADDI, OP_ADCI, OP_SUBI, OP_SBCI, OP_XORI, OP_ORI, OP_ANDI, OP_LDI};
		v = word_t'($random(seed));
		c = 1'b0;
		open_program();
		load_word(3'd1, v);
		for (int i = 0; i < 8; i++) begin	// Chained in place on R1
			k[i] = 8'($random(seed));
			emit(ri_word(ops[i], 3'd1, k[i]));
			store_result(3'd1, 5'(i));
		end
		close_program();
		run_program("immediate ALU");
		for (int i = 0; i < 8; i++) begin
			case (ops[i])
				OP_ADDI: begin s = 17'(v) + 17'(k[i]); v = s[15:0]; c = s[16]; end
				OP_ADCI: begin s = 17'(v) + 17'(k[i]) + 17'(c); v = s[15:0]; c = s[16]; end
				OP_SUBI: begin c = (v >= 16'(k[i])); v = v - 16'(k[i]); end
				OP_SBCI: v = v - 16'(k[i]) - 16'(!c);
				OP_XORI: v = v ^ 16'(k[i]);
				OP_ORI:  v = v | 16'(k[i]);
				OP_ANDI: v = v & 16'(k[i]);
				default: v = 16'(k[i]);	// LDI is unsigned
			endcase
			check_store(8'h80 + 8'(i), v, ops[i].name());
		end
	endtask

	task automatic branch_test(word_t x, logic [7:0] k, string label);
		word_t      diff;
		logic [6:0] taken;
		open_program();
		load_word(3'd2, x);
		for (int cond = 0; cond < 7; cond++) begin
			emit(ri_word(OP_LDI, 3'd5, 8'h5A));	// Marker for taken
			emit(ri_word(OP_CMPI, 3'd2, k));
			emit(branch_word(3'(cond), 12'd1));	// Skips the next word
			emit(ri_word(OP_LDI, 3'd5, 8'hC3));	// Marker for not taken
			store_result(3'd5, 5'(cond));
		end
		close_program();
		run_program(label);
		diff = x - 16'(k);
		taken[0] = (diff == '0);	// Z
		taken[1] = (diff != '0);
		taken[2] = (x >= 16'(k));	// C, no borrow
		taken[3] = (x < 16'(k));
		taken[4] = diff[15];	// N
		taken[5] = !diff[15];
		taken[6] = x[15] && !diff[15];	// V, immediate is positive
		for (int cond = 0; cond < 7; cond++) begin
			check_store(8'h80 + 8'(cond), taken[cond] ? 16'h005A : 16'h00C3,
				$sformatf("%s marker for condition %0d", label, cond));
		end
	endtask

	task automatic shift_test();
		word_t      x;
		logic [3:0] n;
		x = word_t'($random(seed)) | 16'h8000;	// Sign set so SHR and SHRA differ
		n = 4'($random(seed));
		if (n == 4'd0) n = 4'd5;
		open_program();
		load_word(3'd1, x);
		emit(misc_word(3'd3, {1'b0, n[3:2]}, 3'd1, n[1:0]));	// RORI
		store_result(3'd3, 5'd0);
		emit(misc_word(3'd3, 3'b100, 3'd1, 2'b01));	// SHR
		store_result(3'd3, 5'd1);
		emit(misc_word(3'd3, 3'b100, 3'd1, 2'b10));	// SHRA
		store_result(3'd3, 5'd3);
		emit(misc_word(3'd4, 3'b101, 3'd1, 2'b00));	// NOT
		store_result(3'd4, 5'd4);
		emit(misc_word(3'd3, 3'b101, 3'd1, 2'b01));	// NEG
		store_result(3'd3, 5'd5);
		emit(misc_word(3'd5, 3'b100, 3'd4, 2'b01));	// C gets the inverted x[0]
		emit(misc_word(3'd3, 3'b100, 3'd1, 2'b00));	// RORC
		store_result(3'd3, 5'd2);
		close_program();
		run_program("shifts");
		check_store(8'h80, (x >> n) | (x << (5'd16 - 5'(n))), "RORI");
		check_store(8'h81, {1'b0, x[15:1]}, "SHR");
		check_store(8'h82, {~x[0], x[15:1]}, "RORC");
		check_store(8'h83, {x[15], x[15:1]}, "SHRA");
		check_store(8'h84, ~x, "NOT");
		check_store(8'h85, 16'h0000 - x, "NEG");
	endtask

	task automatic load_store_test();
		word_t      x;
		logic [7:0] base;
		logic [4:0] off;
		x = word_t'($random(seed));
		base = 8'hA0 | 8'($random(seed) & 15);
		off = 5'($random(seed) & 15);
		open_program();
		emit(ri_word(OP_LDI, 3'd1, base));
		load_word(3'd2, x);
		emit(mem_word(OP_ST, 3'd2, 3'd1, off));
		emit(mem_word(OP_LD, 3'd3, 3'd1, off));	// Same address
		store_result(3'd3, 5'd0);
		close_program();
		run_program("load and store");
		check_store(base + 8'(off), x, "ST data");
		check_store(8'h80, x, "LD data stored again");
	endtask

	task automatic call_test();
		int    jal_at;
		word_t d;
		d = word_t'($random(seed));
		open_program();
		jal_at = prog.size();
		emit(jal_word(12'(SUB_ADDR - jal_at - 1)));
		store_result(LINK, 5'd0);	// Runs after the return
		emit(misc_word(3'd4, 3'b111, 3'd0, 2'b00));	// LDPC R4
		emit(d);	// Data word, skipped
		store_result(3'd4, 5'd1);
		store_result(3'd5, 5'd2);
		close_program();
		while (prog.size() < SUB_ADDR) emit(branch_word(3'd7, 12'hFFF));
		emit(ri_word(OP_LDI, 3'd5, 8'h77));	// Proves the subroutine ran
		emit(misc_word(3'd0, 3'b111, LINK, 2'b10));	// JIND through link
		run_program("calls");
		check_store(8'h80, word_t'(jal_at + 1), "link register");
		check_store(8'h81, d, "LDPC word");
		check_store(8'h82, 16'h0077, "subroutine marker");
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		word_t      x;
		logic [7:0] k;
		reset = 1'b1;
		seed = 32'h972c;
		alu_register_test();
		alu_immediate_test();
		x = word_t'($random(seed));
		k = 8'($random(seed));
		branch_test(x, k, "CMPI random");
		branch_test(16'(k), k, "CMPI equal");	// Z set
		branch_test(16'h8000 | 16'($random(seed) & 15), 8'h40, "CMPI overflow");
		shift_test();
		load_store_test();
		call_test();
		if (fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
source/gus16_pkg.sv
source/gus16_fetch.sv
source/gus16_decode.sv
source/gus16_execute.sv
source/gus16_result.sv
source/gus16_core.sv
dv/tb_gus16.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the GUS16 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_gus16 \
	--Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/Vtb_gus16 > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
exit 0
